//--- bench/piano_golden.txt
// Piano trainer golden data, every value in hex
// Header: number of games, then the song as SONG_LEN note indices
// Game: action count, expected result, expected score, expected best score
//   result codes: 1 won, 2 wrong note, 3 timeout, 4 short hold
// Action: kind, repeat count, extra key, delay after player_turn, hold cycles
//   kinds: 0 correct note, 1 random wrong key, 2 chord of song note and extra key,
//          3 song note held too briefly, 4 no key pressed
6
4 2 0 2 4 4 4 7
// Game 1: wrong key on the second note of round 3
2 2 4 4
0 4 0 5 8
1 1 0 7 9
// Game 2: chord on the first note of round 2
2 2 1 4
0 1 0 2 9
2 1 b 4 8
// Game 3: whole song played correctly
2 1 24 24
0 14 0 3 8
0 10 0 1a c
// Game 4: no key on the second note of round 2
2 3 2 24
0 2 0 6 a
4 1 0 0 0
// Game 5: first note of round 3 held too briefly
2 4 3 24
0 3 0 2 8
3 1 0 3 1
// Game 6: wrong key on the very first note
1 2 0 24
1 1 0 9 a

//--- bench/piano_trainer_assert.sv
/*
 * Output assertions for the piano trainer top level
 * Show and player phases exclusive, won and lost exclusive, shown notes from the song
 */

module piano_trainer_assert import piano_pkg::*; (
    input logic  clock,
    input logic  reset,
    input logic  show_valid,
    input note_t show_note,
    input logic  player_turn,
    input logic  won,
    input logic  lost
);

    int fail_count = 0;

    function automatic logic in_song(input note_t n);
        logic found;
        found = 1'b0;
        for (int i = 0; i < SONG_LEN; i++) begin
            if (SONG[i] == n) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    show_turn_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(show_valid && player_turn)
    ) else begin
        $error("show_valid and player_turn are high together");
        fail_count++;
    end

    won_lost_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(won && lost)
    ) else begin
        $error("won and lost are high together");
        fail_count++;
    end

    shown_note_in_song: assert property (
        @(posedge clock) disable iff (reset) show_valid |-> in_song(show_note)
    ) else begin
        $error("show_note is not a note of the song");
        fail_count++;
    end

endmodule

//--- bench/tb_piano_trainer.sv
/*
 * Testbench for the piano trainer
 * Plays the games of the golden file and checks show phase, echo and results
 */

module tb_piano_trainer import piano_pkg::*, game_pkg::*;;

    logic    clock;
    logic    reset;
    logic    start;
    keys_t   keys;
    logic    show_valid;
    note_t   show_note;
    logic    player_turn;
    logic    play_note;
    note_t   played_note;
    round_t  round;
    result_t result;
    logic    won;
    logic    lost;
    score_t  score;
    score_t  best_score;

    logic [15:0] golden [0:255];
    note_t       song_exp [0:SONG_LEN-1];
    int          gidx;
    int          shows_seen;
    logic        show_prev;
    int          checks;
    int          errors;
    int          cycles = 0;
    int          cycle_limit = 32'h7fff_ffff;

    piano_trainer i_piano_trainer (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .keys        (keys),
        .show_valid  (show_valid),
        .show_note   (show_note),
        .player_turn (player_turn),
        .play_note   (play_note),
        .played_note (played_note),
        .round       (round),
        .result      (result),
        .won         (won),
        .lost        (lost),
        .score       (score),
        .best_score  (best_score)
    );

    bind piano_trainer piano_trainer_assert i_piano_trainer_assert (
        .clock       (clock),
        .reset       (reset),
        .show_valid  (show_valid),
        .show_note   (show_note),
        .player_turn (player_turn),
        .won         (won),
        .lost        (lost)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    // Run limit
    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Run stopped after %0d cycles without reaching the end", cycles);
            $display("%0d checks, %0d errors", checks, errors + 1);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_note(input note_t got, input note_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_result(input result_t got, input result_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %s, expected %s", $time, what,
                     got.name(), exp.name());
        end
    endtask

    task automatic check_score(input score_t got, input score_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_round(input round_t got, input round_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_show_count(input int round_n);
        checks++;
        if (shows_seen != round_n) begin
            errors++;
            $display("mismatch at %0t: round %0d showed %0d notes, expected %0d",
                     $time, round_n, shows_seen, round_n);
        end
        shows_seen = 0;
    endtask

    // Each rising edge of show_valid is the next song position
    always @(negedge clock) begin
        if (show_valid && !show_prev) begin
            if (shows_seen < SONG_LEN) begin
                check_note(show_note, song_exp[shows_seen], "show_note");
            end else begin
                errors++;
                $display("More notes were shown than the song holds at %0t", $time);
            end
            shows_seen++;
        end
        show_prev = show_valid;
    end

    // ------------------------------
    // Player actions
    // ------------------------------
    function automatic keys_t note_mask(input note_t n);
        return keys_t'(1) << n;
    endfunction

    function automatic note_t lowest_note(input keys_t mask);
        note_t n;
        logic  found;
        n     = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_KEYS; i++) begin
            if (mask[i] && !found) begin
                n     = note_t'(i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    task automatic press_keys(input keys_t mask, input int delay, input int hold);
        repeat (delay) @(negedge clock);
        keys = mask;
        repeat (hold) @(negedge clock);
        // Still held here, so the echo must be up
        if (hold >= MIN_HOLD) begin
            check_flag(play_note, 1'b1, "play_note while held");
            check_note(played_note, lowest_note(mask), "played_note");
        end
        keys = '0;
    endtask

    task automatic wait_turn(output logic ok);
        while (!player_turn && result == res_none) begin
            @(negedge clock);
        end
        ok = player_turn;
    endtask

    task automatic start_game();
        shows_seen = 0;
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        @(negedge clock);
        check_result(result, res_none, "result after start");
        check_score(score, '0, "score after start");
    endtask

    task automatic run_game(input int game_no);
        int      n_act;
        int      kind;
        int      reps;
        int      delay;
        int      hold;
        int      round_n;
        int      pos;
        note_t   extra;
        note_t   wrong;
        result_t exp_res;
        score_t  exp_score;
        score_t  exp_best;
        logic    turn_ok;
        logic    alive;

        n_act     = int'(golden[gidx]);
        exp_res   = result_t'(golden[gidx+1][2:0]);
        exp_score = score_t'(golden[gidx+2][5:0]);
        exp_best  = score_t'(golden[gidx+3][5:0]);
        gidx      = gidx + 4;
        round_n   = 1;
        pos       = 0;
        alive     = 1'b1;
        start_game();
        for (int a = 0; a < n_act; a++) begin
            kind  = int'(golden[gidx]);
            reps  = int'(golden[gidx+1]);
            extra = note_t'(golden[gidx+2][3:0]);
            delay = int'(golden[gidx+3]);
            hold  = int'(golden[gidx+4]);
            gidx  = gidx + 5;
            for (int r = 0; r < reps && alive; r++) begin
                wait_turn(turn_ok);
                if (!turn_ok) begin
                    errors++;
                    $display("Game %0d ended before all its actions were played", game_no);
                    alive = 1'b0;
                end else begin
                    check_round(round, round_t'(round_n), "round");
                    if (pos == 0) begin
                        check_show_count(round_n);
                    end
                    case (kind)
                        0: begin
                            press_keys(note_mask(song_exp[pos]), delay, hold);
                            pos++;
                            if (pos == round_n) begin
                                pos = 0;
                                round_n++;
                            end
                        end
                        1: begin
                            do begin
                                wrong = note_t'($urandom % NUM_KEYS);
                            end while (wrong == song_exp[pos]);
                            press_keys(note_mask(wrong), delay, hold);
                        end
                        2: press_keys(note_mask(song_exp[pos]) | note_mask(extra), delay, hold);
                        3: press_keys(note_mask(song_exp[pos]), delay, hold);
                        default: begin
                        end
                    endcase
                end
            end
        end
        while (result == res_none) begin
            @(negedge clock);
        end
        check_result(result, exp_res, "result");
        check_score(score, exp_score, "score");
        check_score(best_score, exp_best, "best_score");
        check_flag(won, exp_res == res_won, "won");
        check_flag(lost, exp_res != res_won, "lost");
    endtask

    // Upper bound on run length from the golden actions
    function automatic int cycle_budget();
        int idx;
        int n_act;
        int per_rep;
        int total;
        idx   = 1 + SONG_LEN;
        total = 50;
        for (int g = 0; g < int'(golden[0]); g++) begin
            n_act = int'(golden[idx]);
            idx   = idx + 4;
            total = total + 20;
            for (int a = 0; a < n_act; a++) begin
                per_rep = int'(golden[idx+3]) + int'(golden[idx+4]) + 10
                        + SONG_LEN * (SHOW_CYCLES + 1);
                if (golden[idx] == 16'h4) begin
                    per_rep = per_rep + TIMEOUT_CYCLES;
                end
                total = total + int'(golden[idx+1]) * per_rep;
                idx   = idx + 5;
            end
        end
        return total + total / 4;
    endfunction

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int n_games;
        int assert_fails;

        reset      = 1'b1;
        start      = 1'b0;
        keys       = '0;
        checks     = 0;
        errors     = 0;
        gidx       = 0;
        shows_seen = 0;
        show_prev  = 1'b0;
        n_games    = 0;
        void'($urandom(32'hd1d7_277e));
        $readmemh("bench/piano_golden.txt", golden);
        if ($isunknown(golden[0]) || golden[0] == '0) begin
            errors++;
            $display("Golden file bench/piano_golden.txt is missing or holds no games");
        end else begin
            n_games = int'(golden[0]);
            for (int i = 0; i < SONG_LEN; i++) begin
                song_exp[i] = note_t'(golden[1+i][3:0]);
            end
            gidx        = 1 + SONG_LEN;
            cycle_limit = cycle_budget();
        end
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int g = 1; g <= n_games; g++) begin
            run_game(g);
        end
        assert_fails = i_piano_trainer.i_piano_trainer_assert.fail_count;
        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- common/game_pkg.sv
/*
 * Game definitions
 * Sequencer states, result codes and timing constants
 */

package game_pkg;

    // Timing in clock cycles
    localparam int SHOW_CYCLES    = 4;
    localparam int TIMEOUT_CYCLES = 40;
    localparam int MIN_HOLD       = 3;

    // Beat timer count
    localparam int TICK_W = $clog2(TIMEOUT_CYCLES + 1);

    typedef logic [TICK_W-1:0] tick_t;

    // Saturating counts
    typedef logic [3:0] hold_t;
    typedef logic [5:0] score_t;

    typedef enum logic [3:0] {
        st_idle,
        st_new,
        st_show,
        st_gap,
        st_turn,
        st_play,
        st_judge,
        st_done
    } game_state_t;

    typedef enum logic [2:0] {
        res_none       = 3'd0,
        res_won        = 3'd1,
        res_wrong_note = 3'd2,
        res_timeout    = 3'd3,
        res_short      = 3'd4
    } result_t;

endpackage

//--- common/piano_pkg.sv
/*
 * Piano keyboard and song definitions
 * Note and key types plus the built-in song table
 */

package piano_pkg;

    // Keyboard
    localparam int NUM_KEYS = 12;

    typedef logic [3:0]          note_t;
    typedef logic [NUM_KEYS-1:0] keys_t;

    // Song
    localparam int SONG_LEN = 8;

    typedef logic [2:0] song_idx_t;
    typedef logic [3:0] round_t;

    // Indices into the 12-key keyboard, position 0 first
    localparam note_t SONG [0:SONG_LEN-1] = '{
        4'd4, 4'd2, 4'd0, 4'd2, 4'd4, 4'd4, 4'd4, 4'd7
    };

endpackage

//--- common/trainer_ifs.sv
/*
 * Trainer interfaces
 * Key events from the decoder and verdicts from the sequencer
 */

interface key_event_if import piano_pkg::*, game_pkg::*; ();
    logic  press;
    logic  released;
    note_t note;
    logic  chord;
    hold_t hold;

    modport source (output press, released, note, chord, hold);
    modport sink   (input  press, released, note, chord, hold);
endinterface

interface verdict_if import game_pkg::*; ();
    logic    new_game;
    logic    hit;
    logic    done;
    result_t result;

    modport source (output new_game, hit, done, result);
    modport sink   (input  new_game, hit, done, result);
endinterface

//--- project.f
common/piano_pkg.sv
common/game_pkg.sv
common/trainer_ifs.sv
src/key_decode.sv
sequencer/beat_timer.sv
sequencer/game_sequencer.sv
src/game_result.sv
src/piano_trainer.sv
bench/piano_trainer_assert.sv
bench/tb_piano_trainer.sv

//--- run_sim.sh
#!/bin/sh
# Build the piano trainer testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_piano_trainer \
    -f project.f -o tb_piano_trainer > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_piano_trainer +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "CHECKS FAILED: simulator exited with an error" >> sim.log
grep -q "CHECKS FAILED" sim.log \
    && { echo "Simulation failed, see sim.log"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

//--- sequencer/beat_timer.sv
/*
 * Beat timer
 * Down-counter giving one expired strobe a set number of cycles after load
 */

module beat_timer import game_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  load,
    input  tick_t length,
    input  logic  cancel,
    output logic  expired
);

    tick_t count;
    logic  running;

    assign expired = running && (count == '0);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count   <= '0;
            running <= 1'b0;
        end else if (load) begin
            count   <= length - 1'b1;
            running <= 1'b1;
        end else if (cancel || expired) begin
            running <= 1'b0;
        end else if (running) begin
            count <= count - 1'b1;
        end
    end

endmodule

//--- sequencer/game_sequencer.sv
/*
 * Game sequencer
 * Runs rounds of show and player phases and judges each played note
 * against the song table
 */

module game_sequencer import piano_pkg::*, game_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         start,
    key_event_if.sink    ev,
    verdict_if.source    vd,
    output logic         show_valid,
    output note_t        show_note,
    output logic         player_turn,
    output logic         play_note,
    output note_t        played_note,
    output round_t       round
);

    game_state_t state;
    game_state_t next_state;
    song_idx_t   pos;
    result_t     res_q;
    result_t     end_code;

    logic  tmr_load;
    logic  tmr_cancel;
    logic  tmr_expired;
    tick_t tmr_len;

    logic last_pos;
    logic final_round;
    logic note_wrong;
    logic note_short;
    logic note_ok;

    beat_timer i_beat_timer (
        .clock   (clock),
        .reset   (reset),
        .load    (tmr_load),
        .length  (tmr_len),
        .cancel  (tmr_cancel),
        .expired (tmr_expired)
    );

    assign last_pos    = (round_t'(pos) == round - round_t'(1));
    assign final_round = (round == round_t'(SONG_LEN));

    // Chord beats wrong note beats short hold
    assign note_wrong = ev.chord || (ev.note != SONG[pos]);
    assign note_short = ev.hold < hold_t'(MIN_HOLD);
    assign note_ok    = !note_wrong && !note_short;

    // ----------------------------
    // Next state and timer control
    // ----------------------------
    always_comb begin
        next_state = state;
        tmr_load   = 1'b0;
        tmr_cancel = 1'b0;
        tmr_len    = tick_t'(SHOW_CYCLES);
        end_code   = res_none;
        case (state)
            st_idle: begin
                if (start) begin
                    next_state = st_new;
                end
            end
            st_new: begin
                tmr_load   = 1'b1;
                next_state = st_show;
            end
            st_show: begin
                if (tmr_expired) begin
                    next_state = st_gap;
                end
            end
            st_gap: begin
                tmr_load = 1'b1;
                if (last_pos) begin
                    tmr_len    = tick_t'(TIMEOUT_CYCLES);
                    next_state = st_turn;
                end else begin
                    next_state = st_show;
                end
            end
            st_turn: begin
                if (ev.press) begin
                    tmr_cancel = 1'b1;
                    next_state = st_play;
                end else if (tmr_expired) begin
                    end_code   = res_timeout;
                    next_state = st_done;
                end
            end
            st_play: begin
                if (ev.released) begin
                    next_state = st_judge;
                end
            end
            st_judge: begin
                if (note_wrong) begin
                    end_code   = res_wrong_note;
                    next_state = st_done;
                end else if (note_short) begin
                    end_code   = res_short;
                    next_state = st_done;
                end else if (!last_pos) begin
                    tmr_load   = 1'b1;
                    tmr_len    = tick_t'(TIMEOUT_CYCLES);
                    next_state = st_turn;
                end else if (final_round) begin
                    end_code   = res_won;
                    next_state = st_done;
                end else begin
                    // Next round starts with its show phase
                    tmr_load   = 1'b1;
                    next_state = st_show;
                end
            end
            st_done: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // ----------------------------
    // State, position and round
    // ----------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            pos   <= '0;
            round <= round_t'(1);
            res_q <= res_none;
        end else begin
            state <= next_state;
            if (next_state == st_done) begin
                res_q <= end_code;
            end
            case (state)
                st_idle: begin
                    if (start) begin
                        pos   <= '0;
                        round <= round_t'(1);
                    end
                end
                st_gap: begin
                    pos <= last_pos ? song_idx_t'(0) : pos + 1'b1;
                end
                st_judge: begin
                    if (note_ok && !last_pos) begin
                        pos <= pos + 1'b1;
                    end else if (note_ok && !final_round) begin
                        pos   <= '0;
                        round <= round + 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Outputs
    assign show_valid  = (state == st_show);
    assign show_note   = SONG[pos];
    assign player_turn = (state == st_turn);
    assign play_note   = (state == st_play);
    assign played_note = ev.note;

    assign vd.new_game = (state == st_new);
    assign vd.hit      = (state == st_judge) && note_ok;
    assign vd.done     = (state == st_done);
    assign vd.result   = res_q;

endmodule

//--- src/game_result.sv
/*
 * Result stage
 * Latches the outcome of a game and keeps current and best score
 */

module game_result import game_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    verdict_if.sink    vd,
    output result_t    result,
    output logic       won,
    output logic       lost,
    output score_t     score,
    output score_t     best_score
);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result     <= res_none;
            score      <= '0;
            best_score <= '0;
        end else begin
            if (vd.new_game) begin
                result <= res_none;
                score  <= '0;
            end else if (vd.hit && score != '1) begin
                score <= score + 1'b1;
            end
            // Last hit is already counted when done arrives
            if (vd.done) begin
                result <= vd.result;
                if (score > best_score) begin
                    best_score <= score;
                end
            end
        end
    end

    assign won  = (result == res_won);
    assign lost = (result != res_none) && (result != res_won);

endmodule

//--- src/key_decode.sv
/*
 * Key decoder
 * Registers the keyboard, detects press and release of any key
 * and reports the lowest key, chord flag and hold length
 */

module key_decode import piano_pkg::*, game_pkg::*; (
    input  logic           clock,
    input  logic           reset,
    input  keys_t          keys,
    key_event_if.source    ev
);

    keys_t keys_q;
    logic  any_prev;
    logic  any_now;
    logic  multi;

    function automatic note_t lowest_key(input keys_t k);
        note_t n;
        n = '0;
        for (int i = NUM_KEYS - 1; i >= 0; i--) begin
            if (k[i]) begin
                n = note_t'(i);
            end
        end
        return n;
    endfunction

    assign any_now = |keys_q;
    // More than one bit set
    assign multi   = (keys_q & (keys_q - 1'b1)) != '0;

    // ----------------------------
    // Input register and edges
    // ----------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            keys_q      <= '0;
            any_prev    <= 1'b0;
            ev.press    <= 1'b0;
            ev.released <= 1'b0;
        end else begin
            keys_q      <= keys;
            any_prev    <= any_now;
            ev.press    <= any_now && !any_prev;
            ev.released <= !any_now && any_prev;
        end
    end

    // ----------------------------
    // Note payload
    // ----------------------------
    always_ff @(posedge clock) begin
        if (any_now && !any_prev) begin
            ev.note  <= lowest_key(keys_q);
            ev.chord <= multi;
            ev.hold  <= hold_t'(1);
        end else if (any_now) begin
            ev.chord <= ev.chord | multi;
            // Saturates at 15
            if (ev.hold != '1) begin
                ev.hold <= ev.hold + 1'b1;
            end
        end
    end

endmodule

//--- src/piano_trainer.sv
/*
 * Piano trainer top level
 * Key decoder, game sequencer and result stage of the follow-the-leader game
 */

module piano_trainer import piano_pkg::*, game_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    start,
    input  keys_t   keys,
    output logic    show_valid,
    output note_t   show_note,
    output logic    player_turn,
    output logic    play_note,
    output note_t   played_note,
    output round_t  round,
    output result_t result,
    output logic    won,
    output logic    lost,
    output score_t  score,
    output score_t  best_score
);

    key_event_if key_ev ();
    verdict_if   verdict ();

    key_decode i_key_decode (
        .clock (clock),
        .reset (reset),
        .keys  (keys),
        .ev    (key_ev.source)
    );

    game_sequencer i_game_sequencer (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .ev          (key_ev.sink),
        .vd          (verdict.source),
        .show_valid  (show_valid),
        .show_note   (show_note),
        .player_turn (player_turn),
        .play_note   (play_note),
        .played_note (played_note),
        .round       (round)
    );

    game_result i_game_result (
        .clock      (clock),
        .reset      (reset),
        .vd         (verdict.sink),
        .result     (result),
        .won        (won),
        .lost       (lost),
        .score      (score),
        .best_score (best_score)
    );

endmodule
